// ==== dv/tinyCpuTb.sv ====
// Outputs compared every cycle against an ISA model with fixed phase timing; inputs static per run
`timescale 1ns/1ps
`default_nettype none

module tinyCpuTb;
  import tinyCpuPkg::*;

  localparam int   clkHalf    = 2;       // 4 ns period
  localparam int   driveDelay = 1;
  localparam addrT dataBase   = 12'h100; // Above any program
  localparam int   dataWords  = 16;
  localparam int   numProgs   = 2;

  logic clk;
  logic reset;
  logic loadEn;
  addrT loadAddr;
  wordT loadData;
  wordT in0, in1, in2, in3;
  wordT out0, out1, out2, out3;

  wordT    prog [$];           // Program being built
  wordT    modelMem [memWords];
  wordT    stk [stackDepth];   // Model stack, entry 0 is top
  wordT    inVal [numPorts];
  wordT    expOut [numPorts];
  int      evEdge [$];         // Model OUT writes, by clock edge after release
  portSelT evPort [$];
  wordT    evVal [$];
  int      execCount;
  int      errors;
  int      seedDummy;
  bit      running;
  int      cycleCount;
  int      cycleLimit;

  tinyCpu UUT (
    .clk      (clk),
    .reset    (reset),
    .loadEn   (loadEn),
    .loadAddr (loadAddr),
    .loadData (loadData),
    .in0      (in0),
    .in1      (in1),
    .in2      (in2),
    .in3      (in3),
    .out0     (out0),
    .out1     (out1),
    .out2     (out2),
    .out3     (out3)
  );

  initial
  begin
    clk = 1'b0;
    forever #clkHalf clk = ~clk;
  end

  // Run limit, counted from release
  always @(posedge clk)
  begin
    if (!running)
      cycleCount <= 0;
    else
    begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit)
      begin
        $display("Timeout: core still running after %0d cycles at %0t", cycleCount, $time);
        $display("FAIL: see errors above");
        $fatal(1);
      end
    end
  end

  // Watches the bound sequencer checker
  always @(UUT.decode0.chk0.failCount)
  begin
    if (UUT.decode0.chk0.failCount != 0)
    begin
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  task automatic checkValue(input string name, input wordT got, input wordT exp);
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic checkOuts();
    checkValue("out0", out0, expOut[0]);
    checkValue("out1", out1, expOut[1]);
    checkValue("out2", out2, expOut[2]);
    checkValue("out3", out3, expOut[3]);
  endtask

  task automatic emit(input opcodeT op, input logic [11:0] arg);
    prog.push_back({2'b00, op, arg});
  endtask

  function automatic wordT fillWord(input addrT addr);
    return (wordT'(addr) * 18'd2731) ^ 18'h15A5A; // Whole address mixed in
  endfunction

  //////////////////////////////////////////////////
  // Random program builder
  //////////////////////////////////////////////////
  task automatic genProgram();
    int   base;
    addrT dAddr;
    prog.delete();
    while (prog.size() < 50)
    begin
      base  = prog.size();
      dAddr = dataBase + addrT'($urandom_range(dataWords - 1, 0));
      case ($urandom_range(7, 0))
        0:
        begin
          emit(OP_PUSHI, 12'($urandom));
          emit(OP_PUSHI, 12'($urandom));
          emit(OP_OP, 12'($urandom_range(15, 0))); // Binary ALU codes
        end
        1:
        begin
          emit(OP_PUSHI, 12'($urandom));
          emit(OP_OP, 12'(NEG) + 12'($urandom_range(2, 0))); // NEG, BNOT or NOT
        end
        2:
        begin
          repeat ($urandom_range(10, 1)) // Can go past the stack depth
          begin
            if ($urandom_range(1, 0))
              emit(OP_IN, 12'($urandom_range(3, 0)));
            else
              emit(OP_PUSHI, 12'($urandom));
          end
          case ($urandom_range(3, 0))
            0:       emit(OP_OP, 12'(DUP));
            1:       emit(OP_OP, 12'(DROP));
            2:       emit(OP_OP, 12'(DROPNEXT));
            default: emit(OP_OP, 12'(OVER));
          endcase
        end
        3:
        begin
          emit(OP_PUSHI, 12'($urandom));
          emit(OP_POP, dAddr);
          emit(OP_PUSH, dAddr);
        end
        4:
        begin
          emit(OP_PUSHI, dAddr);         // Address under the value
          emit(OP_PUSHI, 12'($urandom));
          emit(OP_ST, 12'h000);
          emit(OP_PUSHI, dAddr);
          emit(OP_LD, 12'h000);
        end
        5:
        begin
          emit(OP_PUSHI, $urandom_range(1, 0) ? 12'h000 : 12'($urandom));
          emit($urandom_range(1, 0) ? OP_JZ : OP_JNZ, 12'(base + 3)); // Taken skips one
          emit(OP_PUSHI, 12'($urandom));
        end
        6:
        begin
          emit(OP_PPPC, 12'h000);                          // Pushes base + 1
          emit(OP_PUSHI, 12'($urandom_range(4, 3)));
          emit(OP_OP, 12'(ADD));
          emit(OP_PPPC, 12'h001);                          // Lands at base + 4 or 5
          emit(OP_PUSHI, 12'($urandom));
        end
        default:
        begin
          emit(OP_JMP, 12'(base + 2));
          emit(OP_PUSHI, 12'($urandom));
        end
      endcase
      emit(OP_OUT, 12'($urandom_range(3, 0))); // Each block closes with an OUT
    end
    emit(OP_JMP, 12'(prog.size())); // Parks on itself
  endtask

  //////////////////////////////////////////////////
  // ISA model
  //////////////////////////////////////////////////
  task automatic pushStack(input wordT v);
    for (int i = stackDepth - 1; i > 0; i--)
      stk[i] = stk[i-1]; // Bottom entry falls off
    stk[0] = v;
  endtask

  task automatic popStack();
    for (int i = 0; i < stackDepth - 1; i++)
      stk[i] = stk[i+1]; // Bottom entry stays
  endtask

  function automatic wordT aluResult(input aluFuncT f, input wordT b, input wordT a);
    case (f)
      ADD:     return b + a;
      SUB:     return b - a;
      MUL:     return b * a;
      SHL:     return b << a;
      SHR:     return b >> a;
      BAND:    return b & a;
      BOR:     return b | a;
      BXOR:    return b ^ a;
      AND:     return wordT'((b != 0) && (a != 0));
      OR:      return wordT'((b != 0) || (a != 0));
      EQ:      return wordT'(b == a);
      NE:      return wordT'(b != a);
      GE:      return wordT'($signed(b) >= $signed(a));
      LE:      return wordT'($signed(b) <= $signed(a));
      GT:      return wordT'($signed(b) > $signed(a));
      LT:      return wordT'($signed(b) < $signed(a));
      NEG:     return -a;
      BNOT:    return ~a;
      NOT:     return wordT'(a == 0);
      default: return '0;
    endcase
  endfunction

  task automatic runModel();
    addrT        pc;
    addrT        pcNow;
    opcodeT      op;
    logic [11:0] arg;
    logic [15:0] imm16;
    wordT        a;
    wordT        b;
    wordT        res;
    aluFuncT     f;
    int          edgeNum;
    bit          done;
    for (int i = 0; i < stackDepth; i++)
      stk[i] = '0;
    evEdge.delete();
    evPort.delete();
    evVal.delete();
    pc        = '0;
    edgeNum   = 1; // First FETCHA begins one edge after release
    execCount = 0;
    done      = 1'b0;
    while (!done)
    begin
      pcNow = pc;
      op    = modelMem[pc][15:12];
      arg   = modelMem[pc][11:0];
      a     = stk[0];
      b     = stk[1];
      pc    = pc + 1'b1;
      execCount++;
      if (execCount > 1000)
      begin
        $display("Model never reached the final self jump");
        $display("FAIL: see errors above");
        $fatal(1);
      end
      case (op)
        OP_PUSHI:
        begin
          imm16 = 16'($signed(arg));
          pushStack({2'b00, imm16});
        end
        OP_PUSH: pushStack(modelMem[arg]);
        OP_POP:
        begin
          modelMem[arg] = a;
          popStack();
        end
        OP_JMP:
        begin
          done = (arg == pcNow);
          pc   = arg;
        end
        OP_JZ, OP_JNZ:
        begin
          popStack(); // Condition always consumed
          if ((op == OP_JZ && a == 0) || (op == OP_JNZ && a != 0))
            pc = arg;
        end
        OP_LD: stk[0] = modelMem[a[addrWidth-1:0]];
        OP_ST:
        begin
          modelMem[b[addrWidth-1:0]] = a;
          popStack();
          popStack();
        end
        OP_PPPC:
        begin
          if (!arg[0])
            pushStack(wordT'(pc)); // Already past this instruction
          else
          begin
            pc = a[addrWidth-1:0];
            popStack();
          end
        end
        OP_IN: pushStack(inVal[arg[1:0]]);
        OP_OUT:
        begin
          evEdge.push_back(edgeNum + 3); // Written as EXECA ends
          evPort.push_back(arg[1:0]);
          evVal.push_back(a);
          popStack();
        end
        OP_OP:
        begin
          f = aluFuncT'(arg[4:0]);
          if (!arg[4])
          begin
            res = aluResult(f, b, a);
            popStack();
            stk[0] = res;
          end
          else if (f == DUP)
            pushStack(a);
          else if (f == OVER)
            pushStack(b);
          else if (f == DROP)
            popStack();
          else if (f == DROPNEXT)
          begin
            popStack();
            stk[0] = a;
          end
          else
            stk[0] = aluResult(f, b, a);
        end
        default: ; // Halt and spare codes do nothing
      endcase
      edgeNum += (op == OP_PUSH || op == OP_LD || op == OP_ST) ? 4 : 3;
    end
  endtask

  //////////////////////////////////////////////////
  // Reset, load and run
  //////////////////////////////////////////////////
  task automatic resetAndLoad();
    int total;
    total  = prog.size() + dataWords;
    reset  = 1'b0;
    loadEn = 1'b0;
    for (int p = 0; p < numPorts; p++)
      inVal[p] = wordT'($urandom);
    in0 = inVal[0];
    in1 = inVal[1];
    in2 = inVal[2];
    in3 = inVal[3];
    repeat (10) @(posedge clk);
    for (int i = 0; i < total; i++)
    begin
      @(posedge clk);
      #driveDelay;
      loadEn = 1'b1;
      if (i < prog.size())
      begin
        loadAddr = addrT'(i);
        loadData = prog[i];
      end
      else
      begin
        loadAddr = dataBase + addrT'(i - prog.size()); // Data region fill
        loadData = fillWord(loadAddr);
      end
      modelMem[loadAddr] = loadData;
    end
    @(posedge clk); // Last word lands here
    #driveDelay;
    loadEn = 1'b0;
  endtask

  task automatic runAndCheck();
    int runCycles;
    int ev;
    runCycles = 4 * execCount + 16;
    for (int p = 0; p < numPorts; p++)
      expOut[p] = '0;
    checkOuts(); // Cleared by reset
    reset      = 1'b1;
    cycleLimit = 4 * prog.size() + 64;
    running    = 1'b1;
    ev         = 0;
    for (int k = 1; k <= runCycles; k++)
    begin
      @(posedge clk);
      #driveDelay;
      while (ev < evEdge.size() && evEdge[ev] == k)
      begin
        expOut[evPort[ev]] = evVal[ev];
        ev++;
      end
      checkOuts();
    end
    running = 1'b0;
  endtask

  initial
  begin
    errors   = 0;
    running  = 1'b0;
    reset    = 1'b0;
    loadEn   = 1'b0;
    loadAddr = '0;
    loadData = '0;
    in0      = '0;
    in1      = '0;
    in2      = '0;
    in3      = '0;
    seedDummy = $urandom(2);
    for (int n = 0; n < numProgs; n++)
    begin
      genProgram();
      resetAndLoad();
      runModel();
      runAndCheck();
    end
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tinyCpu_chk.sv ====
// Bound into cpuDecode by module name; sees the sequencer state and strobes, no datapath values
`timescale 1ns/1ps
`default_nettype none

module decodeChk (
  input logic                 clk,
  input logic                 reset,
  input tinyCpuPkg::cpuStateT state,
  input logic                 pcInc,
  input logic                 pcLoad,
  input logic                 dbusToPc,
  input logic                 push,
  input logic                 pop,
  input logic                 dbusToQtop,
  input logic                 memWrite,
  input logic                 outWrite
);
  import tinyCpuPkg::*;

  logic anyStrobe;
  int   failCount = 0; // Assertion failures so far

  assign anyStrobe = pcInc | pcLoad | dbusToPc | push | pop | dbusToQtop | memWrite | outWrite;

  //////////////////////////////////////////////////
  // Phase order
  //////////////////////////////////////////////////
  fetchOrder: assert property (@(posedge clk) disable iff (!reset)
    state == FETCHA |=> state == FETCHB)
    else
    begin
      $error("FETCHA was not followed by FETCHB");
      failCount++;
    end

  execBOrder: assert property (@(posedge clk) disable iff (!reset)
    state == EXECB |=> state == FETCHA)
    else
    begin
      $error("EXECB was not followed by FETCHA");
      failCount++;
    end

  // Stack moves one way per cycle
  stackOneWay: assert property (@(posedge clk) disable iff (!reset) !(push && pop))
    else
    begin
      $error("push and pop high in the same cycle");
      failCount++;
    end

  // Reset is synchronous, so strobes go quiet one edge after it is seen
  quietInReset: assert property (@(posedge clk) !reset |=> !anyStrobe)
    else
    begin
      $error("control strobe high while reset is low");
      failCount++;
    end

endmodule

bind cpuDecode decodeChk chk0 (
  .clk        (clk),
  .reset      (reset),
  .state      (state),
  .pcInc      (pcInc),
  .pcLoad     (pcLoad),
  .dbusToPc   (dbusToPc),
  .push       (push),
  .pop        (pop),
  .dbusToQtop (dbusToQtop),
  .memWrite   (memWrite),
  .outWrite   (outWrite)
);

`default_nettype wire

// ==== hdl/cpuDecode.sv ====
// Strobes are levels for one phase only; EXECB is entered only by PUSH, LD and ST
`timescale 1ns/1ps
`default_nettype none

module cpuDecode (
  input  logic              clk,
  input  logic              reset,
  input  tinyCpuPkg::wordT  instr,       // Straight from memory output
  input  tinyCpuPkg::wordT  qtop,        // For the JZ/JNZ test
  output tinyCpuPkg::wordT  irOut,
  output logic              pcInc,
  output logic              pcLoad,
  output logic              dbusToPc,
  output logic              push,
  output logic              pop,
  output logic              dbusToQtop,
  output logic              memWrite,
  output logic              outWrite,
  output logic              pcToAbus,
  output logic              irToAbus,
  output logic              qnextToAbus,
  output logic              qtopToAbus,
  output logic              irToDbus,
  output logic              qtopToDbus,
  output logic              aluToDbus,
  output logic              memToDbus,
  output logic              inToDbus,
  output logic              pcToDbus
);
  import tinyCpuPkg::*;

  cpuStateT state;
  opcodeT   opcode;
  aluFuncT  func;
  logic     needExecB; // Second exec phase wanted
  logic     qtopZero;

  assign opcode    = opcodeT'(irOut[15:12]);
  assign func      = aluFuncT'(irOut[4:0]);
  assign qtopZero  = (qtop == '0);
  assign needExecB = (opcode == OP_PUSH) || (opcode == OP_LD) || (opcode == OP_ST);

  //////////////////////////////////////////////////
  // Sequencer and instruction register
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      state <= IDLE;
      irOut <= '0;
    end
    else
    begin
      case (state)
        IDLE:    state <= FETCHA;
        FETCHA:  state <= FETCHB;
        FETCHB:
        begin
          state <= EXECA;
          irOut <= instr; // Word read at pc in FETCHA
        end
        EXECA:   state <= needExecB ? EXECB : FETCHA;
        default: state <= FETCHA; // EXECB and stray codes
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Strobe decode
  //////////////////////////////////////////////////
  always_comb
  begin
    pcInc = 1'b0;  pcLoad = 1'b0;  dbusToPc = 1'b0;
    push = 1'b0;  pop = 1'b0;  dbusToQtop = 1'b0;
    memWrite = 1'b0;  outWrite = 1'b0;
    pcToAbus = 1'b0;  irToAbus = 1'b0;  qnextToAbus = 1'b0;  qtopToAbus = 1'b0;
    irToDbus = 1'b0;  qtopToDbus = 1'b0;  aluToDbus = 1'b0;
    memToDbus = 1'b0;  inToDbus = 1'b0;  pcToDbus = 1'b0;
    case (state)
      FETCHA:
      begin
        pcToAbus = 1'b1; // Read address, pc steps past it
        pcInc    = 1'b1;
      end
      EXECA:
      begin
        case (opcode)
          OP_PUSHI: begin irToDbus = 1'b1; dbusToQtop = 1'b1; push = 1'b1; end
          OP_PUSH:  irToAbus = 1'b1;                        // Data lands in EXECB
          OP_POP:   begin irToAbus = 1'b1; qtopToDbus = 1'b1; memWrite = 1'b1; pop = 1'b1; end
          OP_JMP:   begin irToAbus = 1'b1; pcLoad = 1'b1; end
          OP_JZ,
          OP_JNZ:
          begin
            // Taken when zero test matches, condition always popped
            if (qtopZero == (opcode == OP_JZ))
            begin
              irToAbus = 1'b1;
              pcLoad   = 1'b1;
            end
            pop = 1'b1;
          end
          OP_LD:    qtopToAbus = 1'b1;                      // Address on top
          OP_ST:
          begin
            qnextToAbus = 1'b1; // Address under the value
            qtopToDbus  = 1'b1;
            memWrite    = 1'b1;
            pop         = 1'b1; // Second pop in EXECB
          end
          OP_PPPC:
          begin
            if (!irOut[0])
            begin
              pcToDbus = 1'b1; dbusToQtop = 1'b1; push = 1'b1;
            end
            else
            begin
              qtopToDbus = 1'b1; dbusToPc = 1'b1; pop = 1'b1;
            end
          end
          OP_IN:    begin inToDbus = 1'b1; dbusToQtop = 1'b1; push = 1'b1; end
          OP_OUT:   begin qtopToDbus = 1'b1; outWrite = 1'b1; pop = 1'b1; end
          OP_OP:
          begin
            aluToDbus  = 1'b1;
            dbusToQtop = 1'b1;
            pop  = !irOut[4] || (func == DROP) || (func == DROPNEXT); // Binary ops consume b
            push = (func == DUP) || (func == OVER);
          end
          OP_HALT:  ;  // Core never stops
          default:  ;
        endcase
      end
      EXECB:
      begin
        if (opcode == OP_PUSH)
        begin
          memToDbus = 1'b1; dbusToQtop = 1'b1; push = 1'b1;
        end
        else if (opcode == OP_LD)
        begin
          memToDbus = 1'b1; dbusToQtop = 1'b1; // Replace address with data
        end
        else if (opcode == OP_ST)
          pop = 1'b1;
      end
      default: ; // IDLE and FETCHB quiet
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/cpuExecute.sv ====
// Bus selects are prioritized and not checked for one-hot; unselected buses read zero
`timescale 1ns/1ps
`default_nettype none

module cpuExecute (
  input  logic              clk,
  input  logic              reset,
  input  logic              pcInc,
  input  logic              pcLoad,
  input  logic              dbusToPc,
  input  logic              push,
  input  logic              pop,
  input  logic              dbusToQtop,
  input  logic              pcToAbus,
  input  logic              irToAbus,
  input  logic              qnextToAbus,
  input  logic              qtopToAbus,
  input  logic              irToDbus,
  input  logic              qtopToDbus,
  input  logic              aluToDbus,
  input  logic              memToDbus,
  input  logic              inToDbus,
  input  logic              pcToDbus,
  input  tinyCpuPkg::wordT  irOut,
  input  tinyCpuPkg::wordT  memOut,
  input  tinyCpuPkg::wordT  inData,
  output tinyCpuPkg::addrT  memAddr,
  output tinyCpuPkg::wordT  dbus,
  output tinyCpuPkg::wordT  qtop
);
  import tinyCpuPkg::*;

  addrT    pc;
  addrT    pcIn;
  addrT    abus;
  wordT    qnext;
  wordT    aluOut;
  wordT    imm;
  wordT    aBias;    // a with sign bias
  wordT    bBias;
  aluFuncT func;

  assign func    = aluFuncT'(irOut[4:0]);
  assign imm     = {2'b00, {4{irOut[11]}}, irOut[11:0]}; // 16-bit sign extension
  assign memAddr = abus;

  //////////////////////////////////////////////////
  // Program counter
  //////////////////////////////////////////////////
  assign pcIn = dbusToPc ? dbus[addrWidth-1:0] : abus; // poppc vs jumps

  always_ff @(posedge clk)
  begin
    if (!reset)
      pc <= '0;
    else if (pcLoad || dbusToPc)
      pc <= pcIn;
    else if (pcInc)
      pc <= pc + 1'b1;
  end

  cpuStack stack0 (
    .clk   (clk),
    .reset (reset),
    .push  (push),
    .pop   (pop),
    .load  (dbusToQtop),
    .d     (dbus),
    .qtop  (qtop),
    .qnext (qnext)
  );

  //////////////////////////////////////////////////
  // ALU, a is top and b is next
  //////////////////////////////////////////////////
  assign aBias = qtop + signOffset;
  assign bBias = qnext + signOffset;

  always_comb
  begin
    case (func)
      ADD:      aluOut = qnext + qtop;
      SUB:      aluOut = qnext - qtop;
      MUL:      aluOut = qnext * qtop;  // Low word kept
      SHL:      aluOut = qnext << qtop;
      SHR:      aluOut = qnext >> qtop;
      BAND:     aluOut = qnext & qtop;
      BOR:      aluOut = qnext | qtop;
      BXOR:     aluOut = qnext ^ qtop;
      AND:      aluOut = wordT'(qnext != '0 && qtop != '0);
      OR:       aluOut = wordT'(qnext != '0 || qtop != '0);
      EQ:       aluOut = wordT'(qnext == qtop);
      NE:       aluOut = wordT'(qnext != qtop);
      GE:       aluOut = wordT'(bBias >= aBias); // Signed through the bias
      LE:       aluOut = wordT'(bBias <= aBias);
      GT:       aluOut = wordT'(bBias > aBias);
      LT:       aluOut = wordT'(bBias < aBias);
      NEG:      aluOut = -qtop;
      BNOT:     aluOut = ~qtop;
      NOT:      aluOut = wordT'(qtop == '0);
      DUP,
      DROPNEXT: aluOut = qtop;  // Rewritten top keeps a
      DROP,
      OVER:     aluOut = qnext; // Top becomes b
      default:  aluOut = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Bus selectors
  //////////////////////////////////////////////////
  always_comb
  begin
    if (pcToAbus)         abus = pc;
    else if (irToAbus)    abus = irOut[addrWidth-1:0];
    else if (qnextToAbus) abus = qnext[addrWidth-1:0]; // ST address
    else if (qtopToAbus)  abus = qtop[addrWidth-1:0];  // LD address
    else                  abus = '0;
  end

  always_comb
  begin
    if (irToDbus)        dbus = imm;
    else if (qtopToDbus) dbus = qtop;
    else if (aluToDbus)  dbus = aluOut;
    else if (memToDbus)  dbus = memOut;
    else if (inToDbus)   dbus = inData;
    else if (pcToDbus)   dbus = wordT'(pc); // pushpc, zero-extended
    else                 dbus = '0;
  end

endmodule

`default_nettype wire

// ==== hdl/cpuMemory.sv ====
// Load path owns the write port only while reset is low; contents are not cleared by reset
`timescale 1ns/1ps
`default_nettype none

module cpuMemory (
  input  logic              clk,
  input  logic              reset,
  input  logic              loadEn,
  input  tinyCpuPkg::addrT  loadAddr,
  input  tinyCpuPkg::wordT  loadData,
  input  tinyCpuPkg::addrT  memAddr,
  input  tinyCpuPkg::wordT  memData,
  input  logic              memWrite,
  output tinyCpuPkg::wordT  memOut
);
  import tinyCpuPkg::*;

  wordT mem [memWords];
  addrT portAddr;
  wordT portData;
  logic portWrite;

  // Loader in reset, core otherwise
  assign portAddr  = reset ? memAddr  : loadAddr;
  assign portData  = reset ? memData  : loadData;
  assign portWrite = reset ? memWrite : loadEn;

  always_ff @(posedge clk)
  begin
    if (portWrite)
      mem[portAddr] <= portData;
    memOut <= mem[portAddr]; // Read data one cycle later
  end

endmodule

`default_nettype wire

// ==== hdl/cpuPorts.sv ====
// Only four port slots; the select is the low two instruction bits
`timescale 1ns/1ps
`default_nettype none

module cpuPorts (
  input  logic                clk,
  input  logic                reset,
  input  logic                outWrite,
  input  tinyCpuPkg::portSelT portSel,
  input  tinyCpuPkg::wordT    dbus,
  input  tinyCpuPkg::wordT    in0,
  input  tinyCpuPkg::wordT    in1,
  input  tinyCpuPkg::wordT    in2,
  input  tinyCpuPkg::wordT    in3,
  output tinyCpuPkg::wordT    inData,
  output tinyCpuPkg::wordT    out0,
  output tinyCpuPkg::wordT    out1,
  output tinyCpuPkg::wordT    out2,
  output tinyCpuPkg::wordT    out3
);
  import tinyCpuPkg::*;

  wordT outReg [numPorts];

  // OUT writes at the end of EXECA
  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      for (int i = 0; i < numPorts; i++)
        outReg[i] <= '0;
    end
    else if (outWrite)
      outReg[portSel] <= dbus;
  end

  assign out0 = outReg[0];
  assign out1 = outReg[1];
  assign out2 = outReg[2];
  assign out3 = outReg[3];

  always_comb
  begin
    case (portSel)
      2'd0:    inData = in0;
      2'd1:    inData = in1;
      2'd2:    inData = in2;
      default: inData = in3;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/cpuStack.sv ====
// Fixed depth with no overflow flag; the bottom entry is lost on push and repeats on pop
`timescale 1ns/1ps
`default_nettype none

module cpuStack (
  input  logic              clk,
  input  logic              reset,
  input  logic              push,
  input  logic              pop,
  input  logic              load,   // Write d to top
  input  tinyCpuPkg::wordT  d,
  output tinyCpuPkg::wordT  qtop,
  output tinyCpuPkg::wordT  qnext
);
  import tinyCpuPkg::*;

  wordT q [stackDepth];

  assign qtop  = q[0];
  assign qnext = q[1];

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      for (int i = 0; i < stackDepth; i++)
        q[i] <= '0;
    end
    else
    begin
      // Top takes d first, else pulls up
      if (load)
        q[0] <= d;
      else if (pop)
        q[0] <= q[1];
      for (int i = 1; i < stackDepth - 1; i++)
      begin
        if (push)
          q[i] <= q[i-1];
        else if (pop)
          q[i] <= q[i+1];
      end
      if (push)
        q[stackDepth-1] <= q[stackDepth-2]; // Bottom holds on pop
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tinyCpu.sv ====
// Program is loaded through loadEn while reset is low; no handshake and no halt
`timescale 1ns/1ps
`default_nettype none

module tinyCpu (
  input  logic              clk,
  input  logic              reset,
  input  logic              loadEn,
  input  tinyCpuPkg::addrT  loadAddr,
  input  tinyCpuPkg::wordT  loadData,
  input  tinyCpuPkg::wordT  in0,
  input  tinyCpuPkg::wordT  in1,
  input  tinyCpuPkg::wordT  in2,
  input  tinyCpuPkg::wordT  in3,
  output tinyCpuPkg::wordT  out0,
  output tinyCpuPkg::wordT  out1,
  output tinyCpuPkg::wordT  out2,
  output tinyCpuPkg::wordT  out3
);
  import tinyCpuPkg::*;

  wordT    irOut, qtop, dbus, memOut, inData;
  addrT    memAddr;
  portSelT portSel;
  logic    pcInc, pcLoad, dbusToPc, push, pop, dbusToQtop, memWrite, outWrite;
  logic    pcToAbus, irToAbus, qnextToAbus, qtopToAbus;
  logic    irToDbus, qtopToDbus, aluToDbus, memToDbus, inToDbus, pcToDbus;

  assign portSel = portSelT'(irOut[1:0]);

  //////////////////////////////////////////////////
  // Sequencer and control
  //////////////////////////////////////////////////
  cpuDecode decode0 (
    .clk (clk), .reset (reset), .instr (memOut), .qtop (qtop), .irOut (irOut),
    .pcInc (pcInc), .pcLoad (pcLoad), .dbusToPc (dbusToPc),
    .push (push), .pop (pop), .dbusToQtop (dbusToQtop),
    .memWrite (memWrite), .outWrite (outWrite),
    .pcToAbus (pcToAbus), .irToAbus (irToAbus),
    .qnextToAbus (qnextToAbus), .qtopToAbus (qtopToAbus),
    .irToDbus (irToDbus), .qtopToDbus (qtopToDbus), .aluToDbus (aluToDbus),
    .memToDbus (memToDbus), .inToDbus (inToDbus), .pcToDbus (pcToDbus)
  );

  // Datapath
  cpuExecute execute0 (
    .clk (clk), .reset (reset),
    .pcInc (pcInc), .pcLoad (pcLoad), .dbusToPc (dbusToPc),
    .push (push), .pop (pop), .dbusToQtop (dbusToQtop),
    .pcToAbus (pcToAbus), .irToAbus (irToAbus),
    .qnextToAbus (qnextToAbus), .qtopToAbus (qtopToAbus),
    .irToDbus (irToDbus), .qtopToDbus (qtopToDbus), .aluToDbus (aluToDbus),
    .memToDbus (memToDbus), .inToDbus (inToDbus), .pcToDbus (pcToDbus),
    .irOut (irOut), .memOut (memOut), .inData (inData),
    .memAddr (memAddr), .dbus (dbus), .qtop (qtop)
  );

  cpuMemory memory0 (
    .clk (clk), .reset (reset),
    .loadEn (loadEn), .loadAddr (loadAddr), .loadData (loadData),
    .memAddr (memAddr), .memData (dbus), .memWrite (memWrite), // Store data off dbus
    .memOut (memOut)
  );

  cpuPorts ports0 (
    .clk (clk), .reset (reset), .outWrite (outWrite), .portSel (portSel), .dbus (dbus),
    .in0 (in0), .in1 (in1), .in2 (in2), .in3 (in3), .inData (inData),
    .out0 (out0), .out1 (out1), .out2 (out2), .out3 (out3)
  );

endmodule

`default_nettype wire

// ==== hdl/tinyCpuPkg.sv ====
// Shared widths, opcodes and ALU codes of the 18-bit stack core; instruction fields sit in bits 15..0
`default_nettype none

package tinyCpuPkg;

  //////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////
  localparam int wordWidth  = 18;   // Data word and stack entry
  localparam int addrWidth  = 12;   // Memory address and pc
  localparam int memWords   = 4096; // Program plus data
  localparam int stackDepth = 8;
  localparam int numPorts   = 4;    // In and out slots

  typedef logic [wordWidth-1:0] wordT;
  typedef logic [addrWidth-1:0] addrT;
  typedef logic [3:0]           opcodeT;  // Instruction bits 15..12
  typedef logic [1:0]           portSelT; // Instruction bits 1..0

  // Bias that turns unsigned compares into signed ones
  localparam wordT signOffset = wordT'(1) << (wordWidth - 1);

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////
  localparam opcodeT OP_HALT  = 4'b0000; // Decoded as no operation
  localparam opcodeT OP_PUSHI = 4'b0001;
  localparam opcodeT OP_PUSH  = 4'b0010;
  localparam opcodeT OP_POP   = 4'b0011;
  localparam opcodeT OP_JMP   = 4'b0100;
  localparam opcodeT OP_JZ    = 4'b0101;
  localparam opcodeT OP_JNZ   = 4'b0110;
  localparam opcodeT OP_LD    = 4'b0111;
  localparam opcodeT OP_ST    = 4'b1000;
  localparam opcodeT OP_PPPC  = 4'b1001; // Bit 0 picks pushpc or poppc
  localparam opcodeT OP_IN    = 4'b1101;
  localparam opcodeT OP_OUT   = 4'b1110;
  localparam opcodeT OP_OP    = 4'b1111;

  // ALU function field, bits 4..0
  typedef enum logic [4:0] {
    ADD      = 5'b00000,
    SUB      = 5'b00001,
    MUL      = 5'b00010,
    SHL      = 5'b00011,
    SHR      = 5'b00100,
    BAND     = 5'b00101,
    BOR      = 5'b00110,
    BXOR     = 5'b00111,
    AND      = 5'b01000,
    OR       = 5'b01001,
    EQ       = 5'b01010,
    NE       = 5'b01011,
    GE       = 5'b01100,
    LE       = 5'b01101,
    GT       = 5'b01110,
    LT       = 5'b01111,
    NEG      = 5'b10000, // Unary from here on
    BNOT     = 5'b10001,
    NOT      = 5'b10010,
    DUP      = 5'b10011,
    DROP     = 5'b10111,
    DROPNEXT = 5'b11011,
    OVER     = 5'b11111
  } aluFuncT;

  // Sequencer phases
  typedef enum logic [2:0] {
    IDLE   = 3'b000,
    FETCHA = 3'b001,
    FETCHB = 3'b010,
    EXECA  = 3'b011,
    EXECB  = 3'b100
  } cpuStateT;

endpackage

`default_nettype wire

// ==== tinyCpu.f ====
hdl/tinyCpuPkg.sv
hdl/cpuStack.sv
hdl/cpuDecode.sv
hdl/cpuExecute.sv
hdl/cpuMemory.sv
hdl/cpuPorts.sv
hdl/tinyCpu.sv
dv/tinyCpu_chk.sv
dv/tinyCpuTb.sv
